// ==== src/cav_consts.svh ====
`ifndef CAV_CONSTS_SVH
`define CAV_CONSTS_SVH

`default_nettype none

// sample, gain and detune words all share this width
`define CAV_DW 18

// number of modes in the generate loop
// anything from 1 to 4 fits the index and sum widths
`define CAV_MODES 3

// mode index on the config port
`define CAV_IDX_W 2

// mode sum grows by the index width so four full-scale fields cannot wrap
`define CAV_SUM_W (`CAV_DW + `CAV_IDX_W)

// each mode leaks 1/16 of the way toward its scaled drive per update
`define CAV_MODE_SHIFT 4

// detune product scaling sets the rotation per update
`define CAV_DET_SHIFT 20

// gain product scaling puts full-scale gain just under unity
`define CAV_GAIN_SHIFT 17

`default_nettype wire

`endif

// ==== src/cav_pkg.sv ====
`include "cav_consts.svh"
`default_nettype none

package cav_pkg;

	// config port opcode, picks the bank that a write lands in
	typedef enum logic {
		op_set_gain   = 1'b0,
		op_set_detune = 1'b1
	} cav_op_e;

	// four-phase handshake state of the feeder
	typedef enum logic [1:0] {
		cfg_idle    = 2'd0,
		cfg_ack     = 2'd1,
		cfg_release = 2'd2
	} cav_cfg_state_e;

	// wide signed word for products and the reflect difference
	typedef logic signed [2*`CAV_DW+3:0] cav_wide_t;

	// clamp a wide value into an 18-bit signed sample
	function automatic logic signed [`CAV_DW-1:0] cav_sat(input cav_wide_t x);
		// all bits above the sample msb must agree with the sign
		if (x[2*`CAV_DW+3:`CAV_DW-1] == '0 || x[2*`CAV_DW+3:`CAV_DW-1] == '1)
			return x[`CAV_DW-1:0];
		return x[2*`CAV_DW+3] ? {1'b1, {(`CAV_DW-1){1'b0}}} : {1'b0, {(`CAV_DW-1){1'b1}}};
	endfunction

endpackage

`default_nettype wire

// ==== src/cav_drive_feed.sv ====
`timescale 1ns/1ps
`include "cav_consts.svh"
`default_nettype none

module cav_drive_feed
	import cav_pkg::*;
(
	input  wire                            clk,
	input  wire                            rst_n,
	// interleaved waveguide drive with iq high on I
	input  wire signed [`CAV_DW-1:0]       drive,
	input  wire                            iq,
	// four-phase req/ack config write port
	input  wire                            cfg_req,
	input  wire cav_op_e                   cfg_op,
	input  wire        [`CAV_IDX_W-1:0]    cfg_index,
	input  wire signed [`CAV_DW-1:0]       cfg_value,
	output logic                           cfg_ack,
	// drive one register deep into the modes
	output logic signed [`CAV_DW-1:0]      drive_d,
	output logic                           iq_d,
	// drive two registers deep to line up with mode_field in the drain
	output logic signed [`CAV_DW-1:0]      fwd_d,
	output logic                           iq_dd,
	// per-mode coefficient banks
	output logic signed [`CAV_DW-1:0]      gain [`CAV_MODES],
	output logic signed [`CAV_DW-1:0]      detune [`CAV_MODES]
);

	cav_cfg_state_e cfg_state;

	// drive pipeline that never stalls
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive_d <= '0;
			iq_d    <= 1'b0;
			fwd_d   <= '0;
			iq_dd   <= 1'b0;
		end else begin
			drive_d <= drive;
			iq_d    <= iq;
			// prompt forward wave rides one stage behind the mode input
			fwd_d   <= drive_d;
			iq_dd   <= iq_d;
		end
	end

	// handshake FSM plus gain/detune banks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_state <= cfg_idle;
			cfg_ack   <= 1'b0;
			for (int i = 0; i < `CAV_MODES; i++) begin
				gain[i]   <= '0;
				detune[i] <= '0;
			end
		end else begin
			case (cfg_state)
				cfg_idle: begin
					if (cfg_req) begin
						// write now so the modes use it from the cycle ack goes high
						for (int i = 0; i < `CAV_MODES; i++) begin
							// an index past the last mode matches nothing and ack still follows
							if (cfg_index == `CAV_IDX_W'(i)) begin
								case (cfg_op)
									op_set_gain:   gain[i]   <= cfg_value;
									op_set_detune: detune[i] <= cfg_value;
								endcase
							end
						end
						cfg_ack   <= 1'b1;
						cfg_state <= cav_pkg::cfg_ack;
					end
				end
				cav_pkg::cfg_ack: begin
					// hold ack until the master lets go of req
					if (!cfg_req) begin
						cfg_ack   <= 1'b0;
						cfg_state <= cfg_release;
					end
				end
				cfg_release: begin
					// master only sees ack low from here on
					cfg_state <= cfg_idle;
				end
				default: begin
					cfg_ack   <= 1'b0;
					cfg_state <= cfg_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/cav_mode.sv ====
`timescale 1ns/1ps
`include "cav_consts.svh"
`default_nettype none

module cav_mode
	import cav_pkg::*;
(
	input  wire                        clk,
	input  wire                        rst_n,
	// registered drive, I then Q
	input  wire signed [`CAV_DW-1:0]   drive_d,
	input  wire                        iq_d,
	// coupling gain and detuning of this mode
	input  wire signed [`CAV_DW-1:0]   gain,
	input  wire signed [`CAV_DW-1:0]   detune,
	// state component picked by iq_d, one register late
	output logic signed [`CAV_DW-1:0]  mode_field
);

	// I drive held over for the Q cycle update
	logic signed [`CAV_DW-1:0] drv_i;
	// resonator state
	logic signed [`CAV_DW-1:0] st_i;
	logic signed [`CAV_DW-1:0] st_q;

	// raw products
	cav_wide_t prod_i;
	cav_wide_t prod_q;
	cav_wide_t det_i;
	cav_wide_t det_q;
	// scaled drive and rotation terms
	cav_wide_t u_i;
	cav_wide_t u_q;
	cav_wide_t rot_i;
	cav_wide_t rot_q;
	// next state before clamping
	cav_wide_t nxt_i;
	cav_wide_t nxt_q;

	always_comb begin
		// drive coupling, I from the latch and Q straight off drive_d
		prod_i = gain * drv_i;
		prod_q = gain * drive_d;
		u_i    = prod_i >>> `CAV_GAIN_SHIFT;
		u_q    = prod_q >>> `CAV_GAIN_SHIFT;

		// detuning cross terms, this is what turns the phasor
		det_i  = detune * st_i;
		det_q  = detune * st_q;
		rot_i  = det_i >>> `CAV_DET_SHIFT;
		rot_q  = det_q >>> `CAV_DET_SHIFT;

		// leaky integrator step toward u, plus the rotation
		nxt_i  = st_i + ((u_i - st_i) >>> `CAV_MODE_SHIFT) - rot_q;
		nxt_q  = st_q + ((u_q - st_q) >>> `CAV_MODE_SHIFT) + rot_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drv_i      <= '0;
			st_i       <= '0;
			st_q       <= '0;
			mode_field <= '0;
		end else begin
			// old state goes out, the update below lands a cycle later
			mode_field <= iq_d ? st_i : st_q;

			if (iq_d) begin
				drv_i <= drive_d;
			end else begin
				// full I/Q pair available, step the resonator
				st_i <= cav_sat(nxt_i);
				st_q <= cav_sat(nxt_q);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/cav_refl_sum.sv ====
`timescale 1ns/1ps
`include "cav_consts.svh"
`default_nettype none

module cav_refl_sum
	import cav_pkg::*;
(
	input  wire                        clk,
	input  wire                        rst_n,
	// one interleaved field per mode, all in step
	input  wire signed [`CAV_DW-1:0]   mode_field [`CAV_MODES],
	// prompt forward wave, same component as mode_field
	input  wire signed [`CAV_DW-1:0]   fwd_d,
	input  wire                        iq_dd,
	// registered outputs, still I/Q interleaved
	output logic signed [`CAV_DW-1:0]  field,
	output logic signed [`CAV_DW-1:0]  forward,
	output logic signed [`CAV_DW-1:0]  reflect,
	output logic                       out_iq
);

	// full-width sum of the modes
	logic signed [`CAV_SUM_W-1:0] mode_sum;
	// reflection before clamping
	cav_wide_t refl_wide;

	always_comb begin
		mode_sum = '0;
		// single-cycle adder chain, fine for up to four modes
		for (int n = 0; n < `CAV_MODES; n++) begin
			mode_sum = mode_sum + mode_field[n];
		end
		// reflected wave is probe field minus forward, taken before the field clamp
		refl_wide = mode_sum - fwd_d;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			field   <= '0;
			forward <= '0;
			reflect <= '0;
			out_iq  <= 1'b0;
		end else begin
			field   <= cav_sat(mode_sum);
			// forward is already 18 bits, passes unclamped
			forward <= fwd_d;
			reflect <= cav_sat(refl_wide);
			// iq tag follows the data through this stage
			out_iq  <= iq_dd;
		end
	end

endmodule

`default_nettype wire

// ==== src/cav_elec.sv ====
`timescale 1ns/1ps
`include "cav_consts.svh"
`default_nettype none

module cav_elec
	import cav_pkg::*;
(
	input  wire                        clk,
	input  wire                        rst_n,
	// waveguide drive, interleaved, iq high on I
	input  wire signed [`CAV_DW-1:0]   drive,
	input  wire                        iq,
	// coefficient load port
	input  wire                        cfg_req,
	input  wire cav_op_e               cfg_op,
	input  wire        [`CAV_IDX_W-1:0] cfg_index,
	input  wire signed [`CAV_DW-1:0]   cfg_value,
	output logic                       cfg_ack,
	// baseband probe, forward and reflected waves, 3 cycles behind drive
	output logic signed [`CAV_DW-1:0]  field,
	output logic signed [`CAV_DW-1:0]  forward,
	output logic signed [`CAV_DW-1:0]  reflect,
	output logic                       out_iq
);

	// feeder outputs
	logic signed [`CAV_DW-1:0] drive_d;
	logic                      iq_d;
	logic signed [`CAV_DW-1:0] fwd_d;
	logic                      iq_dd;
	logic signed [`CAV_DW-1:0] gain [`CAV_MODES];
	logic signed [`CAV_DW-1:0] detune [`CAV_MODES];
	// mode outputs into the drain
	logic signed [`CAV_DW-1:0] mode_field [`CAV_MODES];

	cav_drive_feed feed (
		.clk       (clk),
		.rst_n     (rst_n),
		.drive     (drive),
		.iq        (iq),
		.cfg_req   (cfg_req),
		.cfg_op    (cfg_op),
		.cfg_index (cfg_index),
		.cfg_value (cfg_value),
		.cfg_ack   (cfg_ack),
		.drive_d   (drive_d),
		.iq_d      (iq_d),
		.fwd_d     (fwd_d),
		.iq_dd     (iq_dd),
		.gain      (gain),
		.detune    (detune)
	);

	// one resonator per passband mode, all see the same drive
	for (genvar m = 0; m < `CAV_MODES; m++) begin : g_mode
		cav_mode mode (
			.clk        (clk),
			.rst_n      (rst_n),
			.drive_d    (drive_d),
			.iq_d       (iq_d),
			.gain       (gain[m]),
			.detune     (detune[m]),
			.mode_field (mode_field[m])
		);
	end

	// sum, reflect and clamp
	cav_refl_sum drain (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode_field (mode_field),
		.fwd_d      (fwd_d),
		.iq_dd      (iq_dd),
		.field      (field),
		.forward    (forward),
		.reflect    (reflect),
		.out_iq     (out_iq)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held through 8 rising edges, released away from the edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/cav_elec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cav_elec_checker (
	input wire clk,
	input wire rst_n,
	input wire iq,
	input wire cfg_req,
	input wire cfg_ack
);

	// ack only rises after the feeder has seen a request
	ack_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> $past(cfg_req)
	) else $error("cfg_ack rose without cfg_req");

	// master keeps req up until ack arrives
	req_holds: assert property (
		@(posedge clk) disable iff (!rst_n)
		(cfg_req && !cfg_ack) |=> cfg_req
	) else $error("cfg_req dropped before cfg_ack");

	// ack released one cycle after req goes away
	ack_follows_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		$fell(cfg_req) |=> !cfg_ack
	) else $error("cfg_ack still high a cycle after cfg_req fell");

	// I and Q strictly interleaved once out of reset
	iq_alternates: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (iq != $past(iq))
	) else $error("iq did not alternate");

endmodule

`default_nettype wire

// ==== testbench/tb_cav_elec.sv ====
`timescale 1ns/1ps
`include "cav_consts.svh"
`default_nettype none

module tb_cav_elec
	import cav_pkg::*;
();

	logic clk;
	logic rst_n;
	logic signed [`CAV_DW-1:0] drive;
	logic iq;
	logic cfg_req;
	cav_op_e cfg_op;
	logic [`CAV_IDX_W-1:0] cfg_index;
	logic signed [`CAV_DW-1:0] cfg_value;
	logic cfg_ack;
	logic signed [`CAV_DW-1:0] field;
	logic signed [`CAV_DW-1:0] forward;
	logic signed [`CAV_DW-1:0] reflect;
	logic out_iq;

	// parsed records from the input file
	byte rec_kind [64];
	int rec_a [64];
	int rec_b [64];
	int rec_c [64];
	int rec_n;
	int run_limit;
	int cycle_cnt;

	// reference model state
	longint m_gain [`CAV_MODES];
	longint m_det [`CAV_MODES];
	longint m_drv_i [`CAV_MODES];
	longint m_st_i [`CAV_MODES];
	longint m_st_q [`CAV_MODES];
	// expected outputs, 4 sampling edges behind the drive
	longint q_field [$];
	longint q_refl [$];
	longint q_fwd [$];
	bit q_iq [$];
	longint last_i_field, last_i_refl, last_q_field, last_q_refl;
	bit next_iq;
	logic [31:0] lfsr;
	// config write waiting for the next step
	bit pend_valid;
	int pend_op, pend_idx, pend_val;

	tb_clk_gen clk_gen (.clk(clk), .rst_n(rst_n));

	cav_elec uut (
		.clk(clk), .rst_n(rst_n), .drive(drive), .iq(iq),
		.cfg_req(cfg_req), .cfg_op(cfg_op), .cfg_index(cfg_index), .cfg_value(cfg_value),
		.cfg_ack(cfg_ack), .field(field), .forward(forward), .reflect(reflect),
		.out_iq(out_iq)
	);

	bind cav_elec cav_elec_checker chk (
		.clk(clk), .rst_n(rst_n), .iq(iq), .cfg_req(cfg_req), .cfg_ack(cfg_ack)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAIL %s got %h expected %h", name, got[`CAV_DW-1:0], exp[`CAV_DW-1:0]);
		$display("Simulation finished: FAIL");
		$fatal(1, "value mismatch");
	endtask

	// 18-bit signed clamp
	function automatic longint clamp18(input longint v);
		if (v > 131071)
			return 131071;
		if (v < -131072)
			return -131072;
		return v;
	endfunction

	// galois lfsr, one shift per bit
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_random(output logic [`CAV_DW-1:0] v);
		v = '0;
		for (int k = 0; k < `CAV_DW; k++) begin
			v = {v[`CAV_DW-2:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// field is the sum before this sample's update, then the Q sample steps each mode
	task automatic model_sample(input longint x, input bit b);
		longint sum, u_i, u_q, ni, nq;
		sum = 0;
		for (int m = 0; m < `CAV_MODES; m++)
			sum = sum + (b ? m_st_i[m] : m_st_q[m]);
		q_field.push_back(clamp18(sum));
		q_refl.push_back(clamp18(sum - x));
		q_fwd.push_back(x);
		q_iq.push_back(b);
		if (b) begin
			last_i_field = clamp18(sum);
			last_i_refl = clamp18(sum - x);
		end else begin
			last_q_field = clamp18(sum);
			last_q_refl = clamp18(sum - x);
		end
		for (int m = 0; m < `CAV_MODES; m++) begin
			if (b) begin
				m_drv_i[m] = x;
			end else begin
				u_i = (m_gain[m] * m_drv_i[m]) >>> `CAV_GAIN_SHIFT;
				u_q = (m_gain[m] * x) >>> `CAV_GAIN_SHIFT;
				ni = m_st_i[m] + ((u_i - m_st_i[m]) >>> `CAV_MODE_SHIFT)
					- ((m_det[m] * m_st_q[m]) >>> `CAV_DET_SHIFT);
				nq = m_st_q[m] + ((u_q - m_st_q[m]) >>> `CAV_MODE_SHIFT)
					+ ((m_det[m] * m_st_i[m]) >>> `CAV_DET_SHIFT);
				m_st_i[m] = clamp18(ni);
				m_st_q[m] = clamp18(nq);
			end
		end
	endtask

	task automatic check_outputs();
		longint ef, er, ew;
		bit ei;
		ef = q_field.pop_front();
		er = q_refl.pop_front();
		ew = q_fwd.pop_front();
		ei = q_iq.pop_front();
		assert (longint'(field) == ef) else report_value("field", 32'(field), 32'(ef));
		assert (longint'(reflect) == er) else report_value("reflect", 32'(reflect), 32'(er));
		assert (longint'(forward) == ew) else report_value("forward", 32'(forward), 32'(ew));
		assert (out_iq == ei) else report_value("out_iq", 32'(out_iq), 32'(ei));
	endtask

	// one clock of streaming drive
	task automatic step(input logic signed [`CAV_DW-1:0] x);
		@(posedge clk);
		check_outputs();
		if (pend_valid) begin
			cfg_req <= 1'b1;
			cfg_op <= cav_op_e'(pend_op[0]);
			cfg_index <= pend_idx[`CAV_IDX_W-1:0];
			cfg_value <= pend_val[`CAV_DW-1:0];
			// new coefficient applies to the sample driven with the request
			if (pend_idx < `CAV_MODES) begin
				if (pend_op[0])
					m_det[pend_idx] = longint'($signed(pend_val[`CAV_DW-1:0]));
				else
					m_gain[pend_idx] = longint'($signed(pend_val[`CAV_DW-1:0]));
			end
			pend_valid = 1'b0;
		end
		drive <= x;
		iq <= next_iq;
		model_sample(longint'(x), next_iq);
		next_iq = !next_iq;
	endtask

	task automatic cfg_write(input int op, input int idx, input int val);
		int waited;
		pend_op = op;
		pend_idx = idx;
		pend_val = val;
		pend_valid = 1'b1;
		step('0);
		waited = 0;
		while (cfg_ack !== 1'b1) begin
			step('0);
			waited++;
		end
		assert (waited == 2) else fail_run("cfg_ack did not rise two cycles after the request");
		cfg_req <= 1'b0;
		waited = 0;
		while (cfg_ack !== 1'b0) begin
			step('0);
			waited++;
		end
		assert (waited == 2) else fail_run("cfg_ack did not fall one cycle after cfg_req fell");
		// next segment must open on an I cycle
		if (!next_iq)
			step('0);
	endtask

	task automatic drive_pairs(input logic signed [`CAV_DW-1:0] xi,
			input logic signed [`CAV_DW-1:0] xq, input int pairs);
		for (int p = 0; p < pairs; p++) begin
			step(xi);
			step(xq);
		end
	endtask

	task automatic random_pairs(input int pairs);
		logic [`CAV_DW-1:0] v;
		for (int p = 0; p < 2 * pairs; p++) begin
			take_random(v);
			step($signed(v));
		end
	endtask

	task automatic read_records();
		int fd, n, writes, pairs;
		string tok, line;
		fd = $fopen("testbench/cav_input.txt", "r");
		if (fd == 0)
			fail_run("could not open testbench/cav_input.txt");
		rec_n = 0;
		writes = 0;
		pairs = 0;
		while (!$feof(fd)) begin
			n = $fscanf(fd, " %s", tok);
			if (n != 1)
				break;
			if (tok[0] == "#") begin
				void'($fgets(line, fd));
			end else begin
				rec_kind[rec_n] = tok[0];
				case (tok[0])
					"w": begin
						n = $fscanf(fd, " %h %h %h", rec_a[rec_n], rec_b[rec_n], rec_c[rec_n]);
						writes++;
					end
					"d": begin
						n = $fscanf(fd, " %h %h %d", rec_a[rec_n], rec_b[rec_n], rec_c[rec_n]);
						pairs += rec_c[rec_n];
					end
					"r": begin
						n = $fscanf(fd, " %d", rec_c[rec_n]);
						pairs += rec_c[rec_n];
					end
					"e": n = $fscanf(fd, " %h %h %h", rec_a[rec_n], rec_b[rec_n], rec_c[rec_n]);
					default: fail_run("unknown record in the input file");
				endcase
				rec_n++;
			end
		end
		$fclose(fd);
		run_limit = 20 * writes + 2 * pairs + 100;
	endtask

	task automatic check_expect(input int sel, input int ef, input int er);
		longint f, r;
		f = sel[0] ? last_i_field : last_q_field;
		r = sel[0] ? last_i_refl : last_q_refl;
		assert (f == longint'($signed(ef[`CAV_DW-1:0])))
			else report_value("field", 32'(f), 32'(ef));
		assert (r == longint'($signed(er[`CAV_DW-1:0])))
			else report_value("reflect", 32'(r), 32'(er));
	endtask

	// run length guard
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > run_limit)
			fail_run("timeout, run exceeded its cycle limit");
	end

	initial begin
		drive <= '0;
		iq <= 1'b0;
		cfg_req <= 1'b0;
		cfg_op <= op_set_gain;
		cfg_index <= '0;
		cfg_value <= '0;
		cycle_cnt = 0;
		lfsr = 32'h66ca;
		next_iq = 1'b1;
		pend_valid = 1'b0;
		for (int m = 0; m < `CAV_MODES; m++) begin
			m_gain[m] = 0;
			m_det[m] = 0;
			m_drv_i[m] = 0;
			m_st_i[m] = 0;
			m_st_q[m] = 0;
		end
		// outputs still showing reset or idle zeros
		for (int k = 0; k < 4; k++) begin
			q_field.push_back(0);
			q_refl.push_back(0);
			q_fwd.push_back(0);
			q_iq.push_back(1'b0);
		end
		read_records();

		repeat (4) @(posedge clk);
		assert (cfg_ack === 1'b0 && out_iq === 1'b0 && field === '0 && forward === '0
			&& reflect === '0) else fail_run("outputs not zero during reset");
		wait (rst_n === 1'b1);
		assert (cfg_ack === 1'b0 && out_iq === 1'b0 && field === '0 && forward === '0
			&& reflect === '0) else fail_run("outputs not zero after reset");

		for (int k = 0; k < rec_n; k++) begin
			case (rec_kind[k])
				"w": cfg_write(rec_a[k], rec_b[k], rec_c[k]);
				"d": drive_pairs(rec_a[k][`CAV_DW-1:0], rec_b[k][`CAV_DW-1:0], rec_c[k]);
				"r": random_pairs(rec_c[k]);
				default: check_expect(rec_a[k], rec_b[k], rec_c[k]);
			endcase
		end
		// flush the pipeline so every driven sample gets compared
		repeat (4) step('0);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/cav_input.txt ====
# w op idx value | d i q pairs | r pairs | e sel field reflect
# hex 18-bit words, pairs in decimal, sel 1 checks the last I sample and 0 the last Q sample
# all gains zero, reflect is minus forward
d 01000 3f000 4
d 20000 20000 4
e 1 00000 1ffff
# mode 0 at gain one half, out-of-range write in between
w 0 0 10000
w 1 3 00123
d 08000 00000 2
e 1 00400 38400
d 08000 00000 40
# mode 1 positive detune, pure-I drive builds Q
w 0 1 10000
w 1 1 10000
d 08000 00000 3
e 0 00040 00040
d 08000 00000 30
# mode 2 negative detune
w 0 2 10000
w 1 2 30000
d 08000 00000 30
# all modes full gain, saturating sum, then random drive
w 0 0 1ffff
w 0 1 1ffff
w 0 2 1ffff
w 1 0 00400
d 1ffff 1ffff 60
r 80
d 20000 20000 30

// ==== tb.f ====
+incdir+src
src/cav_pkg.sv
src/cav_drive_feed.sv
src/cav_mode.sv
src/cav_refl_sum.sv
src/cav_elec.sv
testbench/tb_clk_gen.sv
testbench/cav_elec_checker.sv
testbench/tb_cav_elec.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run from the project root; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cav_elec -o sim_cav &&
./obj_dir/sim_cav || exit 1
